// ==== files.f ====
+incdir+verilog
verilog/fm_pkg.sv
verilog/fm_if.sv
verilog/fm_mmr.sv
verilog/fm_timers.sv
verilog/fm_eg.sv
verilog/fm_pg.sv
verilog/fm_op.sv
verilog/fm_acc.sv
verilog/fm_top.sv
verification/tb_fm_top.sv

// ==== Bender.yml ====
package:
  name: fm_lite

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fm_pkg.sv
      - verilog/fm_if.sv
      - verilog/fm_mmr.sv
      - verilog/fm_timers.sv
      - verilog/fm_eg.sv
      - verilog/fm_pg.sv
      - verilog/fm_op.sv
      - verilog/fm_acc.sv
      - verilog/fm_top.sv
  - target: test
    files:
      - verification/tb_fm_top.sv

// ==== verification/fm_golden.txt ====
# W bank reg data | R status | Q irq_n | N samples to skip
# S left right limiter (hex, 12-bit two's complement)
R 00
Q 1
W 0 24 FF
R 80
W 0 25 00
# Timer A without irq enable leaves flags clear
W 0 27 01
N 10
R 00
Q 1
W 0 27 00
W 0 27 05
N 3
Q 1
N 2
Q 0
R 01
W 0 27 10
N 3
R 00
Q 1
# Timer B, 2 counts of 16 frames each
W 0 26 FE
W 0 27 0A
N 31
Q 1
N 2
Q 0
R 02
W 0 27 20
N 3
R 00
Q 1
# Channel 0, left only
W 0 50 1F
W 0 80 1F
W 0 A4 2C
W 0 A0 00
W 0 B4 80
W 0 28 10
N 2
S 064 000 0
S 12C 000 0
S 1F1 000 0
S 2B2 000 0
S 36B 000 0
S 41C 000 0
W 0 28 00
N 12
S 000 000 0
S 000 000 0
# tl 8 halves channel 0, channel 2 on bank 1 both sides
W 0 40 08
W 1 50 1F
W 1 80 1F
W 1 A4 2C
W 1 A0 00
W 1 B4 C0
W 0 28 10
W 0 28 12
S 096 000 0
S 15C 064 0
S 285 12C 0
S 3A6 1F1 0
# Four channels, limiter then wrap
W 0 28 00
W 0 28 02
W 0 40 00
W 0 51 1F
W 1 51 1F
W 0 A4 3F
W 0 A0 80
W 0 A5 3F
W 0 A1 80
W 1 A4 3F
W 1 A0 80
W 1 A5 3F
W 1 A1 80
W 0 B5 80
W 1 B4 80
W 1 B5 80
W 0 28 10
W 0 28 11
W 0 28 12
W 0 28 13
N 3
S 7FF 000 1
S 91E 000 0
S 548 000 0

// ==== verification/tb_fm_top.sv ====
`timescale 1ns/1ps

module tb_fm_top;
	import fm_pkg::*;

	localparam int WAIT_LIMIT = 64;

	logic       clk;
	logic       rst_n;
	logic [7:0] din;
	logic [1:0] addr;
	logic       cs_n;
	logic       wr_n;
	logic       limiter_en;
	logic [7:0] dout;
	logic       irq_n;
	sample_t    snd_left;
	sample_t    snd_right;
	logic       snd_sample;
	int         checks;

	fm_top uut (
		.clk(clk), .rst_n(rst_n), .din(din), .addr(addr), .cs_n(cs_n),
		.wr_n(wr_n), .limiter_en(limiter_en), .dout(dout), .irq_n(irq_n),
		.snd_left(snd_left), .snd_right(snd_right), .snd_sample(snd_sample)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (dout[7]) begin
			step();
			n++;
			if (n > WAIT_LIMIT)
				stop_run("Timeout: busy flag never cleared");
		end
	endtask

	task automatic wait_sample();
		int n;
		n = 0;
		do begin
			step();
			n++;
			if (n > WAIT_LIMIT)
				stop_run("Timeout: no snd_sample pulse");
		end while (!snd_sample);
	endtask

	task automatic bus_cycle(input logic [1:0] a, input logic [7:0] d);
		addr = a;
		din  = d;
		cs_n = 1'b0;
		wr_n = 1'b0;
		step();
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	// Writes start right after a sample pulse so frame timing is fixed
	task automatic reg_write(input logic bank, input logic [7:0] ra, input logic [7:0] d);
		wait_not_busy();
		wait_sample();
		bus_cycle({bank, 1'b0}, ra);
		bus_cycle({bank, 1'b1}, d);
	endtask

	task automatic check_status(input logic [7:0] exp);
		checks++;
		if (dout !== exp) begin
			$display("ERROR at %0t: status %02h, expected %02h", $time, dout, exp);
			stop_run("Status mismatch");
		end
	endtask

	task automatic check_irq(input logic exp);
		checks++;
		if (irq_n !== exp) begin
			$display("ERROR at %0t: irq_n %b, expected %b", $time, irq_n, exp);
			stop_run("Interrupt mismatch");
		end
	endtask

	task automatic check_sample(input sample_t exp_l, input sample_t exp_r);
		checks++;
		if (snd_left !== exp_l || snd_right !== exp_r) begin
			$display("ERROR at %0t: sample L %0d R %0d, expected L %0d R %0d",
				$time, snd_left, snd_right, exp_l, exp_r);
			stop_run("Sample mismatch");
		end
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [7:0]  cmd;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;

		checks     = 0;
		rst_n      = 1'b0;
		din        = '0;
		addr       = '0;
		cs_n       = 1'b1;
		wr_n       = 1'b1;
		limiter_en = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		step();

		fd = $fopen("verification/fm_golden.txt", "r");
		if (fd == 0)
			stop_run("Cannot open the golden file");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			v1 = '0;
			v2 = '0;
			v3 = '0;
			n = $sscanf(line, "%c %h %h %h", cmd, v1, v2, v3);
			case (cmd)
			"W": reg_write(v1[0], v2[7:0], v3[7:0]);
			"R": check_status(v1[7:0]);
			"Q": check_irq(v1[0]);
			"N": begin
				// Sample count is decimal
				n = $sscanf(line, "%c %d", cmd, v1);
				repeat (v1) wait_sample();
			end
			"S": begin
				limiter_en = v3[0];
				wait_sample();
				check_sample(sample_t'(v1[11:0]), sample_t'(v2[11:0]));
			end
			default: stop_run("Unknown command in the golden file");
			endcase
		end
		$fclose(fd);

		if (checks == 0) begin
			$display("No checks were found in the golden file");
			$display("TEST FAILED");
			$fatal(1, "run stopped");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// ==== verilog/fm_top.sv ====
`timescale 1ns/1ps

module fm_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [7:0]      din,
	input  logic [1:0]      addr,
	input  logic            cs_n,
	input  logic            wr_n,
	input  logic            limiter_en,
	output logic [7:0]      dout,
	output logic            irq_n,
	output fm_pkg::sample_t snd_left,
	output fm_pkg::sample_t snd_right,
	output logic            snd_sample
);
	import fm_pkg::*;

	logic    write;
	logic    busy;
	logic    flag_a;
	logic    flag_b;
	logic    phase_rst;
	atten_t  atten;
	phase_t  phase;
	op_out_t op_out;
	pan_t    op_pan;
	slot_t   op_slot;

	fm_slot_if  slot_bus ();
	fm_timer_if tmr_bus ();

	assign write = !cs_n && !wr_n;
	// Status byte, readable at any time
	assign dout  = {busy, 5'd0, flag_b, flag_a};

	fm_mmr u_mmr (
		.clk(clk), .rst_n(rst_n), .write(write), .addr(addr), .din(din),
		.busy(busy), .slot(slot_bus.ctrl), .tmr(tmr_bus.ctrl)
	);

	fm_timers u_timers (
		.clk(clk), .rst_n(rst_n), .frame_start(slot_bus.frame_start),
		.tmr(tmr_bus.tmr), .flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
	);

	fm_eg u_eg (
		.clk(clk), .rst_n(rst_n), .slot(slot_bus.dp),
		.atten(atten), .phase_rst(phase_rst)
	);

	fm_pg u_pg (
		.clk(clk), .rst_n(rst_n), .phase_rst(phase_rst),
		.slot(slot_bus.dp), .phase(phase)
	);

	// Pan and slot enter at presentation and leave with op_out
	fm_op u_op (
		.clk(clk), .rst_n(rst_n), .phase(phase), .atten(atten),
		.pan_in(slot_bus.pan), .slot_in(slot_bus.slot),
		.op_out(op_out), .pan_out(op_pan), .slot_out(op_slot)
	);

	fm_acc u_acc (
		.clk(clk), .rst_n(rst_n), .limiter_en(limiter_en),
		.op_out(op_out), .pan(op_pan), .slot(op_slot),
		.snd_left(snd_left), .snd_right(snd_right), .snd_sample(snd_sample)
	);

endmodule

// ==== verilog/fm_acc.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_acc (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            limiter_en,
	input  fm_pkg::op_out_t op_out,
	input  fm_pkg::pan_t    pan,
	input  fm_pkg::slot_t   slot,
	output fm_pkg::sample_t snd_left,
	output fm_pkg::sample_t snd_right,
	output logic            snd_sample
);
	import fm_pkg::*;

	logic signed [13:0] acc_l;
	logic signed [13:0] acc_r;
	logic signed [13:0] add_l;
	logic signed [13:0] add_r;
	logic signed [13:0] sum_l;
	logic signed [13:0] sum_r;
	logic               last;

	// Saturate or wrap to 12 bits
	function automatic sample_t clip(input logic signed [13:0] v, input logic lim);
		sample_t res;
		res = v[11:0];
		if (lim && v > 14'sd2047)
			res = {1'b0, {11{1'b1}}};
		else if (lim && v < -14'sd2048)
			res = {1'b1, 11'd0};
		return res;
	endfunction

	assign add_l = pan[1] ? {{2{op_out[11]}}, op_out} : '0;
	assign add_r = pan[0] ? {{2{op_out[11]}}, op_out} : '0;
	// Slot 0 starts a fresh frame
	assign sum_l = (slot == '0 ? 14'sd0 : acc_l) + add_l;
	assign sum_r = (slot == '0 ? 14'sd0 : acc_r) + add_r;
	assign last  = (slot == slot_t'(`FM_SLOTS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_l      <= '0;
			acc_r      <= '0;
			snd_left   <= '0;
			snd_right  <= '0;
			snd_sample <= 1'b0;
		end else begin
			acc_l      <= sum_l;
			acc_r      <= sum_r;
			snd_sample <= last;
			if (last) begin
				snd_left  <= clip(sum_l, limiter_en);
				snd_right <= clip(sum_r, limiter_en);
			end
		end
	end

	// One sample per frame
	a_sample_gap: assert property (@(posedge clk) disable iff (!rst_n)
		snd_sample |=> !snd_sample);

endmodule

// ==== verilog/fm_op.sv ====
`timescale 1ns/1ps

module fm_op (
	input  logic            clk,
	input  logic            rst_n,
	input  fm_pkg::phase_t  phase,
	input  fm_pkg::atten_t  atten,
	input  fm_pkg::pan_t    pan_in,
	input  fm_pkg::slot_t   slot_in,
	output fm_pkg::op_out_t op_out,
	output fm_pkg::pan_t    pan_out,
	output fm_pkg::slot_t   slot_out
);
	import fm_pkg::*;

	// Cycles from slot presentation to op_out
	localparam int DLY = 3;

	logic [3:0]  idx;
	logic [10:0] mag;
	logic [10:0] mag_sh;
	op_out_t     mag_s;
	pan_t        pan_d  [DLY];
	slot_t       slot_d [DLY];

	// Second quadrant runs the table backwards
	assign idx = phase[8] ? ~phase[7:4] : phase[7:4];

	// Quarter sine, sampled at bin centres, full scale 2047
	always_comb begin
		case (idx)
		4'd0:  mag = 11'd100;
		4'd1:  mag = 11'd300;
		4'd2:  mag = 11'd497;
		4'd3:  mag = 11'd690;
		4'd4:  mag = 11'd875;
		4'd5:  mag = 11'd1052;
		4'd6:  mag = 11'd1219;
		4'd7:  mag = 11'd1375;
		4'd8:  mag = 11'd1517;
		4'd9:  mag = 11'd1644;
		4'd10: mag = 11'd1756;
		4'd11: mag = 11'd1850;
		4'd12: mag = 11'd1927;
		4'd13: mag = 11'd1986;
		4'd14: mag = 11'd2025;
		default: mag = 11'd2045;
		endcase
	end

	// Coarse attenuation, one halving per 64 units
	assign mag_sh = mag >> atten[9:6];
	assign mag_s  = {1'b0, mag_sh};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_out <= '0;
			for (int i = 0; i < DLY; i++) begin
				pan_d[i]  <= '0;
				slot_d[i] <= '0;
			end
		end else begin
			// Upper half wave is negative
			op_out    <= phase[9] ? -mag_s : mag_s;
			pan_d[0]  <= pan_in;
			slot_d[0] <= slot_in;
			for (int i = 1; i < DLY; i++) begin
				pan_d[i]  <= pan_d[i-1];
				slot_d[i] <= slot_d[i-1];
			end
		end
	end

	assign pan_out  = pan_d[DLY-1];
	assign slot_out = slot_d[DLY-1];

endmodule

// ==== verilog/fm_pg.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_pg (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           phase_rst,
	fm_slot_if.dp          slot,
	output fm_pkg::phase_t phase
);
	import fm_pkg::*;

	logic [19:0] acc_q [`FM_SLOTS];
	logic [19:0] inc_q;
	logic [19:0] acc_used;
	slot_t       slot_q;

	// Key-on frame starts from phase 0
	assign acc_used = phase_rst ? '0 : acc_q[slot_q];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `FM_SLOTS; i++)
				acc_q[i] <= '0;
			inc_q  <= '0;
			slot_q <= '0;
			phase  <= '0;
		end else begin
			// First stage, increment is fnum scaled by octave then halved
			inc_q  <= ({9'd0, slot.fnum} << slot.block) >> 1;
			slot_q <= slot.slot;
			// Second stage, aligned with phase_rst from the envelope
			acc_q[slot_q] <= acc_used + inc_q;
			phase         <= acc_used[19:10];
		end
	end

endmodule

// ==== verilog/fm_eg.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_eg (
	input  logic           clk,
	input  logic           rst_n,
	fm_slot_if.dp          slot,
	output fm_pkg::atten_t atten,
	output logic           phase_rst
);
	import fm_pkg::*;

	eg_state_t   state_q [`FM_SLOTS];
	atten_t      level_q [`FM_SLOTS];
	logic        key_q   [`FM_SLOTS];
	eg_state_t   state_nxt;
	atten_t      level_nxt;
	atten_t      atten_q;
	logic        key_rise;
	logic        key_fall;
	logic [10:0] att_step;
	logic [10:0] rel_step;
	logic [10:0] total;

	assign key_rise = slot.keyon && !key_q[slot.slot];
	assign key_fall = !slot.keyon && key_q[slot.slot];
	// Step per frame is 4*rate+1
	assign att_step = {4'd0, slot.ar, 2'b00} + 11'd1;
	assign rel_step = {4'd0, slot.rr, 2'b00} + 11'd1;

	always_comb begin
		state_nxt = state_q[slot.slot];
		level_nxt = level_q[slot.slot];
		if (key_rise)
			state_nxt = EG_ATTACK;
		else if (key_fall)
			state_nxt = EG_RELEASE;
		case (state_nxt)
		EG_ATTACK: begin
			// Top rate jumps straight to full level
			if (slot.ar == 5'd31 || {1'b0, level_nxt} <= att_step) begin
				level_nxt = '0;
				state_nxt = EG_SUSTAIN;
			end else begin
				level_nxt = level_nxt - att_step[9:0];
			end
		end
		EG_RELEASE: begin
			if ({1'b0, level_nxt} + rel_step > 11'd1023)
				level_nxt = '1;
			else
				level_nxt = level_nxt + rel_step[9:0];
		end
		default: ;
		endcase
	end

	// Total level weighs 8 attenuation units per step
	assign total = {1'b0, level_nxt} + {1'b0, slot.tl, 3'b000};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `FM_SLOTS; i++) begin
				state_q[i] <= EG_RELEASE;
				level_q[i] <= '1;
				key_q[i]   <= 1'b0;
			end
			atten_q   <= '1;
			atten     <= '1;
			phase_rst <= 1'b0;
		end else begin
			state_q[slot.slot] <= state_nxt;
			level_q[slot.slot] <= level_nxt;
			key_q[slot.slot]   <= slot.keyon;
			phase_rst          <= key_rise;
			atten_q            <= total[10] ? '1 : total[9:0];
			// Extra stage lines atten up with the phase output
			atten              <= atten_q;
		end
	end

endmodule

// ==== verilog/fm_timers.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_timers (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     frame_start,
	fm_timer_if.tmr  tmr,
	output logic     flag_a,
	output logic     flag_b,
	output logic     irq_n
);
	import fm_pkg::*;

	localparam int PW = $clog2(`FM_TB_PRESCALE);

	tval_a_t       cnt_a;
	tval_b_t       cnt_b;
	logic [PW-1:0] pre_b;
	logic          tick_b;
	logic          ovf_a;
	logic          ovf_b;

	assign tick_b = frame_start && (pre_b == PW'(`FM_TB_PRESCALE - 1));
	// Overflow when stepping past the all-ones count
	assign ovf_a  = tmr.load_a && frame_start && (cnt_a == '1);
	assign ovf_b  = tmr.load_b && tick_b && (cnt_b == '1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_a  <= '0;
			cnt_b  <= '0;
			pre_b  <= '0;
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			// Stopped timers hold their reload value
			if (!tmr.load_a)
				cnt_a <= tmr.value_a;
			else if (frame_start)
				cnt_a <= ovf_a ? tmr.value_a : cnt_a + 1'b1;

			if (!tmr.load_b) begin
				cnt_b <= tmr.value_b;
				pre_b <= '0;
			end else if (frame_start) begin
				pre_b <= tick_b ? '0 : pre_b + 1'b1;
				if (tick_b)
					cnt_b <= ovf_b ? tmr.value_b : cnt_b + 1'b1;
			end

			// Sticky until cleared
			flag_a <= (flag_a && !tmr.clr_a) || (ovf_a && tmr.irq_en_a);
			flag_b <= (flag_b && !tmr.clr_b) || (ovf_b && tmr.irq_en_b);
		end
	end

	assign irq_n = !(flag_a || flag_b);

	// An interrupt only follows a timer with its enable set
	a_irq_src: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(irq_n) |-> $past(tmr.irq_en_a || tmr.irq_en_b));

endmodule

// ==== verilog/fm_mmr.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_mmr (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       write,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	output logic       busy,
	fm_slot_if.ctrl    slot,
	fm_timer_if.ctrl   tmr
);
	import fm_pkg::*;

	localparam int BW = $clog2(`FM_BUSY_CYCLES + 1);

	logic [7:0]    addr_q;
	logic          bank_q;
	logic [BW-1:0] busy_cnt;
	logic          data_wr;
	logic [7:0]    reg_base;
	slot_t         wr_ch;
	slot_t         slot_cnt;
	tval_a_t       value_a_q;
	tval_b_t       value_b_q;
	logic [3:0]    tctl_q;
	logic          clr_a_q;
	logic          clr_b_q;

	tl_t    tl_q    [`FM_SLOTS];
	rate_t  ar_q    [`FM_SLOTS];
	rate_t  rr_q    [`FM_SLOTS];
	fnum_t  fnum_q  [`FM_SLOTS];
	block_t block_q [`FM_SLOTS];
	pan_t   pan_q   [`FM_SLOTS];
	logic   keyon_q [`FM_SLOTS];

	// Data writes are dropped while busy
	assign data_wr  = write && addr[0] && !busy;
	assign busy     = (busy_cnt != '0);
	assign reg_base = {addr_q[7:1], 1'b0};
	// Channel is bank bit then low address bit
	assign wr_ch    = {bank_q, addr_q[0]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q    <= '0;
			bank_q    <= 1'b0;
			value_a_q <= '0;
			value_b_q <= '0;
			tctl_q    <= '0;
			clr_a_q   <= 1'b0;
			clr_b_q   <= 1'b0;
			for (int i = 0; i < `FM_SLOTS; i++) begin
				tl_q[i]    <= '0;
				ar_q[i]    <= '0;
				rr_q[i]    <= '0;
				fnum_q[i]  <= '0;
				block_q[i] <= '0;
				pan_q[i]   <= '0;
				keyon_q[i] <= 1'b0;
			end
		end else begin
			clr_a_q <= 1'b0;
			clr_b_q <= 1'b0;
			if (write && !addr[0]) begin
				addr_q <= din;
				bank_q <= addr[1];
			end
			if (data_wr) begin
				// Global registers live in bank 0 only
				if (!bank_q) begin
					case (addr_q)
					`FM_REG_TA_HI: value_a_q[9:2] <= din;
					`FM_REG_TA_LO: value_a_q[1:0] <= din[1:0];
					`FM_REG_TB:    value_b_q <= din;
					`FM_REG_TCTL: begin
						tctl_q  <= din[3:0];
						clr_a_q <= din[4];
						clr_b_q <= din[5];
					end
					`FM_REG_KEY:   keyon_q[din[1:0]] <= din[4];
					default: ;
					endcase
				end
				if (!addr_q[1]) begin
					case (reg_base)
					`FM_REG_TL:  tl_q[wr_ch] <= din[6:0];
					`FM_REG_AR:  ar_q[wr_ch] <= din[4:0];
					`FM_REG_RR:  rr_q[wr_ch] <= din[4:0];
					`FM_REG_FLO: fnum_q[wr_ch][7:0] <= din;
					`FM_REG_FHI: begin
						block_q[wr_ch]      <= din[5:3];
						fnum_q[wr_ch][10:8] <= din[2:0];
					end
					`FM_REG_PAN: pan_q[wr_ch] <= din[7:6];
					default: ;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_cnt <= '0;
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
			if (data_wr)
				busy_cnt <= BW'(`FM_BUSY_CYCLES);
			else if (busy)
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// Present the current slot
	assign slot.slot        = slot_cnt;
	assign slot.keyon       = keyon_q[slot_cnt];
	assign slot.fnum        = fnum_q[slot_cnt];
	assign slot.block       = block_q[slot_cnt];
	assign slot.tl          = tl_q[slot_cnt];
	assign slot.ar          = ar_q[slot_cnt];
	assign slot.rr          = rr_q[slot_cnt];
	assign slot.pan         = pan_q[slot_cnt];
	assign slot.frame_start = (slot_cnt == '0);

	assign tmr.value_a  = value_a_q;
	assign tmr.value_b  = value_b_q;
	assign tmr.load_a   = tctl_q[0];
	assign tmr.load_b   = tctl_q[1];
	assign tmr.irq_en_a = tctl_q[2];
	assign tmr.irq_en_b = tctl_q[3];
	assign tmr.clr_a    = clr_a_q;
	assign tmr.clr_b    = clr_b_q;

	// Busy window is bounded, writes during busy do not extend it
	a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy) |-> ##[1:`FM_BUSY_CYCLES] !busy);

endmodule

// ==== verilog/fm_if.sv ====
`timescale 1ns/1ps

// Register fields of the slot being presented this cycle
interface fm_slot_if;
	import fm_pkg::*;

	slot_t  slot;
	logic   keyon;
	fnum_t  fnum;
	block_t block;
	tl_t    tl;
	rate_t  ar;
	rate_t  rr;
	pan_t   pan;
	logic   frame_start;

	modport ctrl (output slot, keyon, fnum, block, tl, ar, rr, pan, frame_start);
	modport dp (input slot, keyon, fnum, block, tl, ar, rr, pan, frame_start);
endinterface

// Timer settings, clr_a and clr_b are single-cycle strobes
interface fm_timer_if;
	import fm_pkg::*;

	tval_a_t value_a;
	tval_b_t value_b;
	logic    load_a;
	logic    load_b;
	logic    irq_en_a;
	logic    irq_en_b;
	logic    clr_a;
	logic    clr_b;

	modport ctrl (output value_a, value_b, load_a, load_b, irq_en_a, irq_en_b, clr_a, clr_b);
	modport tmr (input value_a, value_b, load_a, load_b, irq_en_a, irq_en_b, clr_a, clr_b);
endinterface

// ==== verilog/fm_pkg.sv ====
package fm_pkg;

	// Channel and slot index
	typedef logic [1:0] slot_t;

	// Frequency
	typedef logic [10:0] fnum_t;
	typedef logic [2:0] block_t;
	// Top 10 bits of the phase accumulator
	typedef logic [9:0] phase_t;

	// Envelope, 0 is full volume
	typedef logic [9:0] atten_t;
	typedef logic [6:0] tl_t;
	typedef logic [4:0] rate_t;

	// Bit 1 left, bit 0 right
	typedef logic [1:0] pan_t;

	// Signed audio
	typedef logic signed [11:0] op_out_t;
	typedef logic signed [11:0] sample_t;

	// Timer reload values
	typedef logic [9:0] tval_a_t;
	typedef logic [7:0] tval_b_t;

	typedef enum logic [1:0] {
		EG_ATTACK,
		EG_SUSTAIN,
		EG_RELEASE
	} eg_state_t;

endpackage

// ==== verilog/fm_cfg.svh ====
`ifndef FM_CFG_SVH
`define FM_CFG_SVH

// Frame geometry, one slot per channel
`define FM_SLOTS        4

// Cycles of busy after an accepted data write
`define FM_BUSY_CYCLES  8

// Frame ticks per timer B count
`define FM_TB_PRESCALE  16

// Register map
`define FM_REG_TA_HI    8'h24
`define FM_REG_TA_LO    8'h25
`define FM_REG_TB       8'h26
`define FM_REG_TCTL     8'h27
`define FM_REG_KEY      8'h28
// Channel register bases, channel 0/1 on the low address bit
`define FM_REG_TL       8'h40
`define FM_REG_AR       8'h50
`define FM_REG_RR       8'h80
`define FM_REG_FLO      8'hA0
`define FM_REG_FHI      8'hA4
`define FM_REG_PAN      8'hB4

`endif
